// File: bench/tb_clock_gen.sv
// tb_clock_gen: testbench clock of 4 ns and an active low reset held for two cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

// File: bench/tb_frontend.sv
// tb_frontend is the table driven testbench of the fetch frontend with memory and fetch models
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module tb_frontend;

  localparam int NROWS = 10;
  localparam int WAIT_MAX = 300;
  localparam logic [31:0] MEM_KEY = 32'hA5A5_0000;
  localparam logic [31:0] LINE_A = 32'h0000_3000;
  localparam logic [31:0] LINE_B = 32'h0000_3080;
  localparam logic [31:0] LINE_C = 32'h0000_3100;

  // ========================================
  // stimulus table
  // ========================================
  // update kind per row is 0 for none, 1 for taken, 2 for not taken
  // lru mode 1 checks the victims of lines B and C, mode 2 the refetch of line A
  localparam logic [31:0] ROW_PC [NROWS] = '{32'h1000, 32'h1204, 32'h4000, 32'h5000,
    32'h5000, 32'h6000, 32'h3000, 32'h3080, 32'h3100, 32'h3000};
  localparam int ROW_UPD [NROWS] = '{0, 0, 1, 1, 2, 0, 0, 0, 0, 0};
  localparam logic [31:0] ROW_UPC [NROWS] = '{0, 0, 32'h4004, 32'h5000, 32'h5000,
    0, 0, 0, 0, 0};
  localparam logic [31:0] ROW_UTGT [NROWS] = '{0, 0, 32'h4100, 32'h5044, 0,
    0, 0, 0, 0, 0};
  localparam int ROW_NPKT [NROWS] = '{6, 4, 4, 3, 3, 24, 2, 2, 2, 2};
  localparam int ROW_BP [NROWS] = '{0, 0, 0, 0, 0, 1, 1, 1, 1, 1};
  localparam int ROW_LRU [NROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 2};

  logic clk;
  logic rst_n;
  logic ibuffer_valid_o, ibuffer_ready_i;
  frontend_pkg::fetch_data_t ibuffer_data_o;
  frontend_pkg::paddr_t ibuffer_pc_o, ibuffer_pred_npc_o;
  frontend_pkg::slot_mask_t ibuffer_slot_valid_o;
  frontend_pkg::epoch_t ibuffer_fetch_epoch_o;
  logic flush_i, bpu_update_valid_i, bpu_update_taken_i;
  frontend_pkg::paddr_t redirect_pc_i, bpu_update_pc_i, bpu_update_target_i;
  logic miss_req_valid_o, miss_req_ready_i, refill_valid_i, refill_ready_o;
  frontend_pkg::paddr_t miss_req_paddr_o;
  frontend_pkg::way_t miss_req_victim_way_o;
  frontend_pkg::line_t refill_data_i;

  tb_clock_gen i_clk (.clk_o(clk), .rst_n_o(rst_n));

  frontend_top UUT (.clk_i(clk), .rst_n_i(rst_n), .*);

  int data_errs = 0;
  int ctrl_errs = 0;
  int tmo_errs = 0;
  logic [31:0] lfsr_q = 32'h59;
  int bp_on = 0;

  // memory model state
  int mem_state = 0;
  int mem_delay = 0;
  logic [31:0] mem_line, wait_addr;
  logic waiting = 1'b0;
  int miss_cnt [logic [31:0]];
  int miss_way [logic [31:0]];
  int a_way = -1;
  logic [31:0] res_line [2][8];
  logic res_valid [2][8];

  // fetch and predictor model state
  logic [31:0] model_pc;
  logic [2:0] model_epoch = '0;
  logic btb_v [16];
  logic [24:0] btb_tag [16];
  logic btb_slot [16];
  logic [31:0] btb_tgt [16];

  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return lfsr_q[0];
  endfunction

  // line contents from the memory rule with word i at bits 32*i
  function automatic frontend_pkg::line_t build_line(logic [31:0] line);
    frontend_pkg::line_t l;
    for (int i = 0; i < 4; i++) begin
      l[32*i +: 32] = (line + 32'(4 * i)) ^ MEM_KEY;
    end
    return l;
  endfunction

  task automatic accept_miss(logic [31:0] line, int way);
    int set;
    set = int'(line[6:4]);
    assert (!((res_valid[0][set] && res_line[0][set] == line) ||
              (res_valid[1][set] && res_line[1][set] == line))) else begin
      $display("miss request for line %h that is already in the cache", line);
      ctrl_errs++;
    end
    if (line == LINE_A && !miss_cnt.exists(line)) begin
      a_way = way;
    end
    miss_cnt[line] = miss_cnt.exists(line) ? miss_cnt[line] + 1 : 1;
    miss_way[line] = way;
    res_line[way][set] = line;
    res_valid[way][set] = 1'b1;
  endtask

  // ========================================
  // memory side served once per falling edge
  // ========================================
  task automatic serve_memory();
    logic rdy;
    case (mem_state)
      0: begin
        refill_valid_i = 1'b0;
        assert (!refill_ready_o) else begin
          $display("Error: refill_ready_o got %h expected %h", refill_ready_o, 1'b0);
          ctrl_errs++;
        end
        if (miss_req_valid_o) begin
          assert (!waiting || miss_req_paddr_o == wait_addr) else begin
            $display("Error: miss_req_paddr_o got %h expected %h", miss_req_paddr_o, wait_addr);
            ctrl_errs++;
          end
          assert (miss_req_paddr_o[3:0] == 4'h0) else begin
            $display("Error: miss_req_paddr_o got %h expected line aligned", miss_req_paddr_o);
            ctrl_errs++;
          end
          rdy = (bp_on != 0) ? lfsr_bit() : 1'b1;
          miss_req_ready_i = rdy;
          if (rdy) begin
            mem_line = miss_req_paddr_o;
            accept_miss(miss_req_paddr_o, int'(miss_req_victim_way_o));
            mem_delay = (bp_on != 0) ? int'({lfsr_bit(), lfsr_bit()}) : 1;
            mem_state = 1;
            waiting = 1'b0;
          end else begin
            waiting = 1'b1;
            wait_addr = miss_req_paddr_o;
          end
        end else begin
          miss_req_ready_i = 1'b0;
        end
      end
      1: begin
        miss_req_ready_i = 1'b0;
        assert (!miss_req_valid_o) else begin
          $display("Error: miss_req_valid_o got %h expected %h", miss_req_valid_o, 1'b0);
          ctrl_errs++;
        end
        if (mem_delay == 0 && refill_ready_o) begin
          refill_valid_i = 1'b1;
          refill_data_i = build_line(mem_line);
          mem_state = 2;
        end else if (mem_delay > 0) begin
          mem_delay--;
        end
      end
      default: begin
        refill_valid_i = 1'b0;
        mem_state = 0;
      end
    endcase
  endtask

  task automatic step();
    @(negedge clk);
    serve_memory();
  endtask

  task automatic check_packet();
    logic [31:0] blk, npc;
    logic [1:0] mask;
    logic [3:0] idx;
    blk = {model_pc[31:3], 3'b000};
    idx = model_pc[6:3];
    mask = {1'b1, ~model_pc[2]};
    npc = blk + 32'd8;
    if (btb_v[idx] && btb_tag[idx] == model_pc[31:7]) begin
      npc = btb_tgt[idx];
      if (!btb_slot[idx]) begin
        mask[1] = 1'b0;
      end
    end
    assert (ibuffer_pc_o == blk) else begin
      $display("Error: ibuffer_pc_o got %h expected %h", ibuffer_pc_o, blk);
      ctrl_errs++;
    end
    assert (ibuffer_slot_valid_o == mask) else begin
      $display("Error: ibuffer_slot_valid_o got %h expected %h", ibuffer_slot_valid_o, mask);
      ctrl_errs++;
    end
    assert (ibuffer_pred_npc_o == npc) else begin
      $display("Error: ibuffer_pred_npc_o got %h expected %h", ibuffer_pred_npc_o, npc);
      ctrl_errs++;
    end
    assert (ibuffer_fetch_epoch_o == model_epoch) else begin
      $display("Error: ibuffer_fetch_epoch_o got %h expected %h",
               ibuffer_fetch_epoch_o, model_epoch);
      ctrl_errs++;
    end
    assert (ibuffer_data_o == {(blk + 32'd4) ^ MEM_KEY, blk ^ MEM_KEY}) else begin
      $display("Error: ibuffer_data_o got %h expected %h", ibuffer_data_o,
               {(blk + 32'd4) ^ MEM_KEY, blk ^ MEM_KEY});
      data_errs++;
    end
    model_pc = npc;
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    int got;
    int waited;
    logic [3:0] ui;
    ibuffer_ready_i = 1'b0;
    flush_i = 1'b0;
    redirect_pc_i = '0;
    bpu_update_valid_i = 1'b0;
    bpu_update_pc_i = '0;
    bpu_update_taken_i = 1'b0;
    bpu_update_target_i = '0;
    miss_req_ready_i = 1'b0;
    refill_valid_i = 1'b0;
    refill_data_i = '0;
    for (int i = 0; i < 16; i++) begin
      btb_v[i] = 1'b0;
    end
    for (int i = 0; i < 16; i++) begin
      res_valid[i / 8][i % 8] = 1'b0;
    end
    waited = 0;
    while (!rst_n && waited < WAIT_MAX) begin
      @(posedge clk);
      waited++;
    end
    assert (rst_n) else begin
      $display("timeout: reset was never released");
      tmo_errs++;
    end
    @(negedge clk);
    assert (!miss_req_valid_o && !refill_ready_o && !ibuffer_valid_o) else begin
      $display("Error: after reset miss_req_valid_o %h refill_ready_o %h ibuffer_valid_o %h",
               miss_req_valid_o, refill_ready_o, ibuffer_valid_o);
      ctrl_errs++;
    end

    for (int r = 0; r < NROWS; r++) begin
      bp_on = ROW_BP[r];
      step();
      ibuffer_ready_i = 1'b0;
      if (ROW_UPD[r] != 0) begin
        bpu_update_valid_i = 1'b1;
        bpu_update_pc_i = ROW_UPC[r];
        bpu_update_taken_i = (ROW_UPD[r] == 1);
        bpu_update_target_i = ROW_UTGT[r];
        ui = ROW_UPC[r][6:3];
        if (ROW_UPD[r] == 1) begin
          btb_v[ui] = 1'b1;
          btb_tag[ui] = ROW_UPC[r][31:7];
          btb_slot[ui] = ROW_UPC[r][2];
          btb_tgt[ui] = ROW_UTGT[r];
        end else if (btb_tag[ui] == ROW_UPC[r][31:7]) begin
          btb_v[ui] = 1'b0;
        end
      end
      step();
      bpu_update_valid_i = 1'b0;
      flush_i = 1'b1;
      redirect_pc_i = ROW_PC[r];
      model_pc = ROW_PC[r];
      model_epoch = model_epoch + 3'd1;
      step();
      flush_i = 1'b0;

      got = 0;
      waited = 0;
      while (got < ROW_NPKT[r] && waited < WAIT_MAX) begin
        step();
        ibuffer_ready_i = (bp_on != 0) ? lfsr_bit() : 1'b1;
        waited++;
        if (ibuffer_valid_o && ibuffer_ready_i) begin
          check_packet();
          got++;
          waited = 0;
        end
      end
      if (got < ROW_NPKT[r]) begin
        $display("timeout: row %0d received only %0d of %0d packets", r, got, ROW_NPKT[r]);
        tmo_errs++;
      end

      if (ROW_LRU[r] == 1) begin
        assert (miss_way.exists(LINE_B) && miss_way[LINE_B] != a_way) else begin
          $display("line %h replaced the most recently used way %0d", LINE_B, a_way);
          ctrl_errs++;
        end
        assert (miss_way.exists(LINE_C) && miss_way[LINE_C] == a_way) else begin
          $display("line %h did not evict the least recently used way %0d", LINE_C, a_way);
          ctrl_errs++;
        end
      end
      if (ROW_LRU[r] == 2) begin
        assert (miss_cnt.exists(LINE_A) && miss_cnt[LINE_A] == 2) else begin
          $display("evicted line %h was not requested again from memory", LINE_A);
          ctrl_errs++;
        end
      end
    end

    ibuffer_ready_i = 1'b0;
    $display("errors: data %0d, control %0d, timeout %0d", data_errs, ctrl_errs, tmo_errs);
    if (data_errs + ctrl_errs + tmo_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# builds the frontend testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_frontend \
  -o sim_frontend > build.log 2>&1 \
  && ./obj_dir/sim_frontend > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

// File: src.f
+incdir+src
src/frontend_pkg.sv
src/fetch_if.sv
src/fetch_pc_gen.sv
src/icache_core.sv
src/fetch_buffer.sv
src/frontend_top.sv
bench/tb_clock_gen.sv
bench/tb_frontend.sv

// File: src/fetch_buffer.sv
// fetch_buffer: packet FIFO between the instruction cache and the backend
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module fetch_buffer (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  fetch_pkt_if.sink                 pkt,
  output logic                      ibuffer_valid_o,
  input  logic                      ibuffer_ready_i,
  output frontend_pkg::fetch_data_t ibuffer_data_o,
  output frontend_pkg::paddr_t      ibuffer_pc_o,
  output frontend_pkg::slot_mask_t  ibuffer_slot_valid_o,
  output frontend_pkg::paddr_t      ibuffer_pred_npc_o,
  output frontend_pkg::epoch_t      ibuffer_fetch_epoch_o
);

  localparam int DEPTH = `FE_FBUF_DEPTH;

  frontend_pkg::fetch_data_t data_q  [DEPTH];
  frontend_pkg::paddr_t      pc_q    [DEPTH];
  frontend_pkg::slot_mask_t  mask_q  [DEPTH];
  frontend_pkg::paddr_t      npc_q   [DEPTH];
  frontend_pkg::epoch_t      epoch_q [DEPTH];

  // pointers wrap on their own since the depth is a power of two
  logic [`FE_FBUF_PTR_W-1:0] wr_ptr_q;
  logic [`FE_FBUF_PTR_W-1:0] rd_ptr_q;
  logic [`FE_FBUF_CNT_W-1:0] count_q;
  logic                      push;
  logic                      pop;

  assign pkt.ready       = count_q != `FE_FBUF_CNT_W'(DEPTH);
  assign ibuffer_valid_o = count_q != '0;

  // nothing moves in a flush cycle
  assign push = pkt.valid && pkt.ready && !flush_i;
  assign pop  = ibuffer_valid_o && ibuffer_ready_i && !flush_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + `FE_FBUF_CNT_W'(push) - `FE_FBUF_CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[wr_ptr_q]  <= pkt.data;
      pc_q[wr_ptr_q]    <= pkt.pc;
      mask_q[wr_ptr_q]  <= pkt.slot_mask;
      npc_q[wr_ptr_q]   <= pkt.pred_npc;
      epoch_q[wr_ptr_q] <= pkt.epoch;
    end
  end

  assign ibuffer_data_o        = data_q[rd_ptr_q];
  assign ibuffer_pc_o          = pc_q[rd_ptr_q];
  assign ibuffer_slot_valid_o  = mask_q[rd_ptr_q];
  assign ibuffer_pred_npc_o    = npc_q[rd_ptr_q];
  assign ibuffer_fetch_epoch_o = epoch_q[rd_ptr_q];

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= `FE_FBUF_CNT_W'(DEPTH));

endmodule

// File: src/fetch_if.sv
// fetch_if: request and packet handshakes between the frontend stages
`timescale 1ns/1ps

// pc generator to cache, one fetch block per transfer
interface fetch_req_if;
  logic                      valid;
  logic                      ready;
  frontend_pkg::paddr_t      pc;
  frontend_pkg::slot_mask_t  slot_mask;
  frontend_pkg::paddr_t      pred_npc;
  frontend_pkg::epoch_t      epoch;

  modport source (
    output valid, pc, slot_mask, pred_npc, epoch,
    input  ready
  );

  modport sink (
    input  valid, pc, slot_mask, pred_npc, epoch,
    output ready
  );
endinterface

// cache to fetch buffer, request fields plus the fetched words
interface fetch_pkt_if;
  logic                      valid;
  logic                      ready;
  frontend_pkg::paddr_t      pc;
  frontend_pkg::fetch_data_t data;
  frontend_pkg::slot_mask_t  slot_mask;
  frontend_pkg::paddr_t      pred_npc;
  frontend_pkg::epoch_t      epoch;

  modport source (
    output valid, pc, data, slot_mask, pred_npc, epoch,
    input  ready
  );

  modport sink (
    input  valid, pc, data, slot_mask, pred_npc, epoch,
    output ready
  );
endinterface

// File: src/fetch_pc_gen.sv
// fetch_pc_gen: fetch PC register with BTB prediction, redirect and fetch epoch
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module fetch_pc_gen (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  frontend_pkg::paddr_t redirect_pc_i,
  input  logic                 bpu_update_valid_i,
  input  frontend_pkg::paddr_t bpu_update_pc_i,
  input  logic                 bpu_update_taken_i,
  input  frontend_pkg::paddr_t bpu_update_target_i,
  fetch_req_if.source          req
);

  localparam int PLEN = `FE_PLEN;
  localparam int BLK_W = `FE_BLOCK_OFF_W;
  localparam int IDX_W = `FE_BTB_IDX_W;
  localparam int TAG_W = `FE_BTB_TAG_W;

  // ========================================
  // branch target buffer
  // ========================================
  logic [`FE_BTB_ENTRIES-1:0] btb_valid_q;
  logic [TAG_W-1:0]           btb_tag_q    [`FE_BTB_ENTRIES];
  logic                       btb_slot_q   [`FE_BTB_ENTRIES];
  frontend_pkg::paddr_t       btb_target_q [`FE_BTB_ENTRIES];

  logic                     valid_q;
  frontend_pkg::paddr_t     pc_q;
  frontend_pkg::paddr_t     pred_npc_q;
  frontend_pkg::slot_mask_t slot_mask_q;
  frontend_pkg::epoch_t     epoch_q;

  frontend_pkg::paddr_t     next_pc;
  frontend_pkg::paddr_t     next_blk;
  frontend_pkg::paddr_t     next_npc;
  frontend_pkg::slot_mask_t next_mask;
  logic [IDX_W-1:0]         look_idx;
  logic [IDX_W-1:0]         upd_idx;
  logic                     look_hit;
  logic                     upd_match;
  logic                     advance;

  // a new block is chosen on a redirect or once the current one is taken
  assign advance  = flush_i || (req.valid && req.ready);
  assign next_pc  = flush_i ? redirect_pc_i : pred_npc_q;
  assign next_blk = {next_pc[PLEN-1:BLK_W], BLK_W'(0)};

  assign look_idx = next_pc[BLK_W +: IDX_W];
  assign look_hit = btb_valid_q[look_idx] && (btb_tag_q[look_idx] == next_pc[PLEN-1 -: TAG_W]);

  always_comb begin
    next_mask = '1;
    next_npc  = next_blk + PLEN'(`FE_BLOCK_BYTES);
    // entering mid-block skips slot 0
    if (next_pc[BLK_W-1]) begin
      next_mask[0] = 1'b0;
    end
    // hit means predict taken, slots after the branch are dropped
    if (look_hit) begin
      next_npc = btb_target_q[look_idx];
      if (!btb_slot_q[look_idx]) begin
        next_mask[1] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q     <= 1'b0;
      pc_q        <= `FE_RESET_VECTOR;
      slot_mask_q <= '1;
      pred_npc_q  <= `FE_RESET_VECTOR + PLEN'(`FE_BLOCK_BYTES);
      epoch_q     <= '0;
    end else begin
      valid_q <= 1'b1;
      if (advance) begin
        pc_q        <= next_blk;
        slot_mask_q <= next_mask;
        pred_npc_q  <= next_npc;
      end
      if (flush_i) begin
        epoch_q <= epoch_q + 1'b1;
      end
    end
  end

  // ========================================
  // training from the backend
  // ========================================
  assign upd_idx   = bpu_update_pc_i[BLK_W +: IDX_W];
  assign upd_match = btb_tag_q[upd_idx] == bpu_update_pc_i[PLEN-1 -: TAG_W];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      btb_valid_q <= '0;
    end else if (bpu_update_valid_i) begin
      if (bpu_update_taken_i) begin
        btb_valid_q[upd_idx] <= 1'b1;
      end else if (upd_match) begin
        btb_valid_q[upd_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bpu_update_valid_i && bpu_update_taken_i) begin
      btb_tag_q[upd_idx]    <= bpu_update_pc_i[PLEN-1 -: TAG_W];
      btb_slot_q[upd_idx]   <= bpu_update_pc_i[BLK_W-1];
      btb_target_q[upd_idx] <= bpu_update_target_i;
    end
  end

  assign req.valid     = valid_q;
  assign req.pc        = pc_q;
  assign req.slot_mask = slot_mask_q;
  assign req.pred_npc  = pred_npc_q;
  assign req.epoch     = epoch_q;

  // a stalled request keeps its address unless a redirect replaces it
  a_req_pc_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req.valid && !req.ready && !flush_i |=> $stable(req.pc));

endmodule

// File: src/frontend_cfg.svh
// frontend configuration: address, fetch, cache, predictor and buffer sizes
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// ========================================
// base widths
// ========================================
`define FE_PLEN          32
`define FE_ILEN          32
`define FE_FETCH_WIDTH   2
`define FE_EPOCH_W       3
`define FE_RESET_VECTOR  32'h0000_1000

// fetch block of FE_FETCH_WIDTH instructions, 8 bytes
`define FE_BLOCK_BYTES   (`FE_FETCH_WIDTH * `FE_ILEN / 8)
`define FE_BLOCK_OFF_W   ($clog2(`FE_BLOCK_BYTES))

// ========================================
// instruction cache geometry
// ========================================
`define FE_LINE_BYTES    16
`define FE_SETS          8
`define FE_WAYS          2
`define FE_LINE_W        (`FE_LINE_BYTES * 8)
`define FE_WAY_W         ($clog2(`FE_WAYS))
`define FE_OFFSET_W      ($clog2(`FE_LINE_BYTES))
`define FE_INDEX_W       ($clog2(`FE_SETS))
`define FE_TAG_W         (`FE_PLEN - `FE_OFFSET_W - `FE_INDEX_W)

// branch target buffer, indexed by block address
`define FE_BTB_ENTRIES   16
`define FE_BTB_IDX_W     ($clog2(`FE_BTB_ENTRIES))
`define FE_BTB_TAG_W     (`FE_PLEN - `FE_BLOCK_OFF_W - `FE_BTB_IDX_W)

// fetch buffer toward the backend
`define FE_FBUF_DEPTH    4
`define FE_FBUF_PTR_W    ($clog2(`FE_FBUF_DEPTH))
`define FE_FBUF_CNT_W    ($clog2(`FE_FBUF_DEPTH + 1))

`endif

// File: src/frontend_pkg.sv
// frontend_pkg: shared types of the instruction fetch frontend
`include "frontend_cfg.svh"

package frontend_pkg;

  // ========================================
  // address and payload types
  // ========================================
  typedef logic [`FE_PLEN-1:0] paddr_t;
  typedef logic [`FE_ILEN-1:0] instr_t;

  // slot 0 in the low word, slot 1 in the high word
  typedef logic [`FE_FETCH_WIDTH*`FE_ILEN-1:0] fetch_data_t;
  typedef logic [`FE_FETCH_WIDTH-1:0] slot_mask_t;

  // bumped on every redirect, travels with each packet
  typedef logic [`FE_EPOCH_W-1:0] epoch_t;

  // ========================================
  // cache types
  // ========================================
  typedef logic [`FE_WAY_W-1:0] way_t;
  typedef logic [`FE_LINE_W-1:0] line_t;

  // single outstanding miss controller
  typedef enum logic [1:0] {
    LOOKUP,
    MISS_REQ,
    REFILL_WAIT
  } icache_state_e;

endpackage

// File: src/frontend_top.sv
// frontend_top: PC generator, instruction cache and fetch buffer of the fetch frontend
`timescale 1ns/1ps

module frontend_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // ========================================
  // backend side
  // ========================================
  output logic                      ibuffer_valid_o,
  input  logic                      ibuffer_ready_i,
  output frontend_pkg::fetch_data_t ibuffer_data_o,
  output frontend_pkg::paddr_t      ibuffer_pc_o,
  output frontend_pkg::slot_mask_t  ibuffer_slot_valid_o,
  output frontend_pkg::paddr_t      ibuffer_pred_npc_o,
  output frontend_pkg::epoch_t      ibuffer_fetch_epoch_o,

  input  logic                      flush_i,
  input  frontend_pkg::paddr_t      redirect_pc_i,
  input  logic                      bpu_update_valid_i,
  input  frontend_pkg::paddr_t      bpu_update_pc_i,
  input  logic                      bpu_update_taken_i,
  input  frontend_pkg::paddr_t      bpu_update_target_i,

  // ========================================
  // memory side
  // ========================================
  output logic                      miss_req_valid_o,
  input  logic                      miss_req_ready_i,
  output frontend_pkg::paddr_t      miss_req_paddr_o,
  output frontend_pkg::way_t        miss_req_victim_way_o,
  input  logic                      refill_valid_i,
  output logic                      refill_ready_o,
  input  frontend_pkg::line_t       refill_data_i
);

  fetch_req_if req_if ();
  fetch_pkt_if pkt_if ();

  fetch_pc_gen i_pc_gen (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .flush_i             (flush_i),
    .redirect_pc_i       (redirect_pc_i),
    .bpu_update_valid_i  (bpu_update_valid_i),
    .bpu_update_pc_i     (bpu_update_pc_i),
    .bpu_update_taken_i  (bpu_update_taken_i),
    .bpu_update_target_i (bpu_update_target_i),
    .req                 (req_if.source)
  );

  icache_core i_icache (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .flush_i               (flush_i),
    .req                   (req_if.sink),
    .pkt                   (pkt_if.source),
    .miss_req_valid_o      (miss_req_valid_o),
    .miss_req_ready_i      (miss_req_ready_i),
    .miss_req_paddr_o      (miss_req_paddr_o),
    .miss_req_victim_way_o (miss_req_victim_way_o),
    .refill_valid_i        (refill_valid_i),
    .refill_ready_o        (refill_ready_o),
    .refill_data_i         (refill_data_i)
  );

  fetch_buffer i_fbuf (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .flush_i               (flush_i),
    .pkt                   (pkt_if.sink),
    .ibuffer_valid_o       (ibuffer_valid_o),
    .ibuffer_ready_i       (ibuffer_ready_i),
    .ibuffer_data_o        (ibuffer_data_o),
    .ibuffer_pc_o          (ibuffer_pc_o),
    .ibuffer_slot_valid_o  (ibuffer_slot_valid_o),
    .ibuffer_pred_npc_o    (ibuffer_pred_npc_o),
    .ibuffer_fetch_epoch_o (ibuffer_fetch_epoch_o)
  );

endmodule

// File: src/icache_core.sv
// icache_core: two-way set-associative instruction cache with one outstanding miss
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module icache_core (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  fetch_req_if.sink            req,
  fetch_pkt_if.source          pkt,
  output logic                 miss_req_valid_o,
  input  logic                 miss_req_ready_i,
  output frontend_pkg::paddr_t miss_req_paddr_o,
  output frontend_pkg::way_t   miss_req_victim_way_o,
  input  logic                 refill_valid_i,
  output logic                 refill_ready_o,
  input  frontend_pkg::line_t  refill_data_i
);

  localparam int PLEN  = `FE_PLEN;
  localparam int OFF_W = `FE_OFFSET_W;
  localparam int IDX_W = `FE_INDEX_W;
  localparam int TAG_W = `FE_TAG_W;
  localparam int WAYS  = `FE_WAYS;
  localparam int SETS  = `FE_SETS;
  localparam int PKT_W = `FE_FETCH_WIDTH * `FE_ILEN;
  localparam int SEL_W = $clog2(`FE_LINE_W / PKT_W);

  // ========================================
  // arrays and controller state
  // ========================================
  frontend_pkg::icache_state_e            state_q;
  logic [WAYS-1:0][SETS-1:0]              valid_q;
  frontend_pkg::way_t [SETS-1:0]          lru_q;
  logic [TAG_W-1:0]                       tag_q  [WAYS][SETS];
  frontend_pkg::line_t                    data_q [WAYS][SETS];

  // registered request
  logic                     rq_valid_q;
  frontend_pkg::paddr_t     rq_pc_q;
  frontend_pkg::slot_mask_t rq_mask_q;
  frontend_pkg::paddr_t     rq_npc_q;
  frontend_pkg::epoch_t     rq_epoch_q;

  // the line being fetched from memory
  frontend_pkg::paddr_t miss_addr_q;
  frontend_pkg::way_t   victim_q;

  logic [IDX_W-1:0]    rq_idx;
  logic [IDX_W-1:0]    miss_idx;
  logic                hit_any;
  frontend_pkg::way_t  hit_way;
  frontend_pkg::line_t hit_line;
  logic                in_lookup;
  logic                lookup_hit;
  logic                lookup_miss;
  logic                req_fire;
  logic                pkt_fire;
  logic                refill_fire;

  assign rq_idx   = rq_pc_q[OFF_W +: IDX_W];
  assign miss_idx = miss_addr_q[OFF_W +: IDX_W];

  always_comb begin
    hit_any = 1'b0;
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (valid_q[w][rq_idx] && (tag_q[w][rq_idx] == rq_pc_q[PLEN-1 -: TAG_W])) begin
        hit_any = 1'b1;
        hit_way = frontend_pkg::way_t'(w);
      end
    end
  end

  assign in_lookup   = state_q == frontend_pkg::LOOKUP;
  assign lookup_hit  = in_lookup && rq_valid_q && hit_any;
  assign lookup_miss = in_lookup && rq_valid_q && !hit_any;
  assign hit_line    = data_q[hit_way][rq_idx];

  assign pkt_fire    = pkt.valid && pkt.ready;
  assign req_fire    = req.valid && req.ready;
  assign refill_fire = refill_valid_i && refill_ready_o;

  // take a new block when the register empties this cycle
  assign req.ready = in_lookup && !flush_i && (!rq_valid_q || pkt_fire);

  assign pkt.valid     = lookup_hit;
  assign pkt.pc        = rq_pc_q;
  assign pkt.data      = hit_line[rq_pc_q[OFF_W-1 -: SEL_W]*PKT_W +: PKT_W];
  assign pkt.slot_mask = rq_mask_q;
  assign pkt.pred_npc  = rq_npc_q;
  assign pkt.epoch     = rq_epoch_q;

  assign miss_req_valid_o      = state_q == frontend_pkg::MISS_REQ;
  assign miss_req_paddr_o      = miss_addr_q;
  assign miss_req_victim_way_o = victim_q;
  assign refill_ready_o        = state_q == frontend_pkg::REFILL_WAIT;

  // ========================================
  // control: request slot, miss FSM, valid and LRU bits
  // ========================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= frontend_pkg::LOOKUP;
      rq_valid_q <= 1'b0;
      valid_q    <= '0;
      lru_q      <= '0;
    end else begin
      if (flush_i) begin
        rq_valid_q <= 1'b0;
      end else if (req_fire) begin
        rq_valid_q <= 1'b1;
      end else if (pkt_fire) begin
        rq_valid_q <= 1'b0;
      end

      if (lookup_hit) begin
        lru_q[rq_idx] <= ~hit_way;
      end

      case (state_q)
        frontend_pkg::LOOKUP: begin
          if (lookup_miss && !flush_i) begin
            state_q <= frontend_pkg::MISS_REQ;
          end
        end
        frontend_pkg::MISS_REQ: begin
          if (miss_req_ready_i) begin
            state_q <= frontend_pkg::REFILL_WAIT;
          end
        end
        frontend_pkg::REFILL_WAIT: begin
          // the line is kept even if a flush dropped its request
          if (refill_fire) begin
            valid_q[victim_q][miss_idx] <= 1'b1;
            lru_q[miss_idx]             <= ~victim_q;
            state_q                     <= frontend_pkg::LOOKUP;
          end
        end
        default: state_q <= frontend_pkg::LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rq_pc_q    <= req.pc;
      rq_mask_q  <= req.slot_mask;
      rq_npc_q   <= req.pred_npc;
      rq_epoch_q <= req.epoch;
    end
    if (lookup_miss && !flush_i) begin
      miss_addr_q <= {rq_pc_q[PLEN-1:OFF_W], OFF_W'(0)};
      victim_q    <= lru_q[rq_idx];
    end
    if (refill_fire) begin
      tag_q[victim_q][miss_idx]  <= miss_addr_q[PLEN-1 -: TAG_W];
      data_q[victim_q][miss_idx] <= refill_data_i;
    end
  end

  a_miss_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    miss_req_valid_o && !miss_req_ready_i |=> miss_req_valid_o && $stable(miss_req_paddr_o));

  // a refill is only taken after memory accepted the miss request
  a_refill_after_miss: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(refill_ready_o) |-> $past(miss_req_valid_o && miss_req_ready_i));

endmodule
